/* mouse_led.f */
src/mouse_pkg.sv
src/ps2_line_sync.sv
src/ps2_rx.sv
src/ps2_tx.sv
src/mouse_packet.sv
src/cursor_counter.sv
src/led_pattern.sv
src/mouse_led_top.sv
tests/mouse_led_tb.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mouse_led_tb \
  -f mouse_led.f -o mouse_led_sim
./obj_dir/mouse_led_sim > sim.log 2>&1 || {
  cat sim.log
  exit 1
}
cat sim.log
if grep -q "tests failed" sim.log; then
  exit 1
fi

/* tests/mouse_led_tb.sv */
// ps2 mouse led and cursor testbench
module mouse_led_tb import mouse_pkg::*; ();

  localparam int INHIBIT_CYCLES = 50;
  localparam int SEED           = 15740;
  localparam int NUM_PACKETS    = 60;
  localparam int NUM_DIRECTED   = 6;
  // device clock half period in system cycles
  localparam int HALF           = 20;
  localparam int BIT_CYCLES     = 2 * HALF;
  localparam int CMD_WAIT       = 1000;
  // 33 frame bits per packet, doubled, plus command and pre-ack frames
  localparam int WATCHDOG_CYCLES = (NUM_PACKETS + NUM_DIRECTED) * 33 * BIT_CYCLES * 2 +
                                   INHIBIT_CYCLES + 12 * 11 * BIT_CYCLES;

  logic    clk;
  logic    reset;
  logic    ps2c_in;
  logic    ps2d_in;
  logic    ps2c_drive_low;
  logic    ps2d_drive_low;
  led_t    led;
  cursor_t cursor;

  // device side release values
  logic    ps2c_rel;
  logic    ps2d_rel;
  int      error_count = 0;
  cursor_t model_cursor;
  led_t    model_led;

  // open collector bus, either side can pull low
  assign ps2c_in = ps2c_rel & ~ps2c_drive_low;
  assign ps2d_in = ps2d_rel & ~ps2d_drive_low;

  mouse_led_top #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) i_mouse_led_top (
    .clk, .reset, .ps2c_in, .ps2d_in, .ps2c_drive_low, .ps2d_drive_low, .led, .cursor
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ends just after a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string name, input ps2_byte_t exp, input ps2_byte_t act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_cursor(input string name, input cursor_t exp, input cursor_t act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // parity bit set when the byte has an even number of ones
  function automatic logic odd_parity(input ps2_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += int'(b[i]);
    end
    return (ones % 2 == 0);
  endfunction

  // device to host frame: start, 8 data lsb first, odd parity, stop
  task automatic send_byte(input ps2_byte_t b);
    logic [10:0] frame;
    frame = {1'b1, ~^b, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      // data settles mid high phase
      ps2d_rel = frame[i];
      step(HALF / 2);
      ps2c_rel = 1'b0;
      step(HALF);
      ps2c_rel = 1'b1;
      step(HALF / 2);
    end
    ps2d_rel = 1'b1;
    step(BIT_CYCLES);
  endtask

  // host to device command, device clocks and acknowledges
  task automatic get_command(output ps2_byte_t cmd, output logic [1:0] tail,
                             output logic ok);
    logic [9:0] bits;
    int         waited;
    ok     = 1'b0;
    cmd    = '0;
    tail   = '0;
    bits   = '0;
    waited = 0;
    while (!ps2c_drive_low && waited < CMD_WAIT) begin
      step(1);
      waited++;
    end
    if (!ps2c_drive_low) begin
      error_count++;
      $display("device never saw a host command, the clock was never inhibited");
      return;
    end
    waited = 0;
    while (ps2c_drive_low && waited < 4 * INHIBIT_CYCLES) begin
      step(1);
      waited++;
    end
    if (ps2c_drive_low) begin
      error_count++;
      $display("host held the PS/2 clock low and never released it");
      return;
    end
    if (waited < INHIBIT_CYCLES) begin
      error_count++;
      $display("clock inhibit lasted %0d cycles, shorter than required", waited);
    end
    // request to send shows as data low at clock release
    if (!ps2d_drive_low) begin
      error_count++;
      $display("host did not pull data low for the start bit");
    end
    step(HALF);
    for (int i = 0; i < 10; i++) begin
      ps2c_rel = 1'b0;
      step(HALF);
      // sampled at the end of the low phase
      bits[i]  = ps2d_in;
      ps2c_rel = 1'b1;
      step(HALF);
    end
    // acknowledge bit
    ps2d_rel = 1'b0;
    step(5);
    ps2c_rel = 1'b0;
    step(HALF);
    ps2c_rel = 1'b1;
    step(HALF);
    ps2d_rel = 1'b1;
    step(BIT_CYCLES);
    cmd  = bits[7:0];
    tail = bits[9:8];
    ok   = 1'b1;
  endtask

  // expected cursor and led after one report
  task automatic apply_report(input mouse_buttons_t b, input logic sgn, input logic [7:0] low);
    if (b[0])
      model_cursor = '0;
    else if (b[1])
      model_cursor = '1;
    else
      model_cursor = model_cursor + {sgn, sgn, low};
    if (low != 8'd0) begin
      if (sgn && low > 8'd100)
        model_led = {model_led[0], model_led[7:1]};
      else if (low < 8'd100)
        model_led = {model_led[6:0], model_led[7]};
    end else if (b != '0) begin
      if (b[2])
        model_led = {model_led[6:0], model_led[7]};
      else
        model_led = {b, 5'd0};
    end
  endtask

  task automatic run_packet(input string name, input mouse_buttons_t b, input logic sgn,
                            input logic [7:0] low);
    ps2_byte_t head;
    // overflow bits clear, bit 3 always set
    head = {2'b00, 1'($urandom), sgn, 1'b1, b};
    send_byte(head);
    send_byte(low);
    // y byte, dropped by the DUT
    send_byte(ps2_byte_t'($urandom));
    apply_report(b, sgn, low);
    check_cursor({name, " cursor"}, model_cursor, cursor);
    check_led({name, " led"}, model_led, led);
  endtask

  // x mix of zero, near threshold, full range, small of either sign
  task automatic random_move(output logic sgn, output logic [7:0] low);
    case ($urandom % 5)
      0: begin
        low = 8'd0;
        sgn = 1'($urandom);
      end
      1: begin
        low = 8'(95 + $urandom % 11);
        sgn = 1'($urandom);
      end
      2: begin
        low = 8'($urandom);
        sgn = 1'($urandom);
      end
      3: begin
        low = 8'(1 + $urandom % 20);
        sgn = 1'b0;
      end
      default: begin
        low = 8'(236 + $urandom % 20);
        sgn = 1'b1;
      end
    endcase
  endtask

  initial begin
    ps2_byte_t      cmd;
    logic [1:0]     tail;
    logic           got_cmd;
    logic           sgn;
    logic [7:0]     low;
    mouse_buttons_t b;
    void'($urandom(SEED));
    reset    = 1'b1;
    ps2c_rel = 1'b1;
    ps2d_rel = 1'b1;
    step(10);
    reset = 1'b0;
    check_cursor("reset cursor", CURSOR_RESET, cursor);
    check_led("reset led", LED_RESET, led);
    get_command(cmd, tail, got_cmd);
    if (got_cmd) begin
      check_byte("command byte", CMD_STREAM_ENABLE, cmd);
      check_byte("command parity and stop", {6'd0, 1'b1, odd_parity(CMD_STREAM_ENABLE)},
                 {6'd0, tail});
      // packet before the ack must be ignored
      send_byte(8'h0A);
      send_byte(8'h37);
      send_byte(8'h12);
      check_cursor("pre-ack cursor", CURSOR_RESET, cursor);
      check_led("pre-ack led", LED_RESET, led);
      send_byte(RESP_ACK);
      check_cursor("ack cursor", CURSOR_RESET, cursor);
      check_led("ack led", LED_RESET, led);
      model_cursor = CURSOR_RESET;
      model_led    = LED_RESET;
      run_packet("left over right", 3'b011, 1'b0, 8'd5);
      run_packet("right saturate", 3'b010, 1'b0, 8'd0);
      run_packet("middle rotate", 3'b100, 1'b0, 8'd0);
      run_packet("threshold hold", 3'b000, 1'b0, 8'd100);
      run_packet("negative threshold hold", 3'b000, 1'b1, 8'd100);
      run_packet("rotate right", 3'b000, 1'b1, 8'd150);
      for (int n = 0; n < NUM_PACKETS; n++) begin
        random_move(sgn, low);
        // about half the packets carry no buttons
        b = ($urandom % 2 == 0) ? mouse_buttons_t'(0) : mouse_buttons_t'($urandom);
        run_packet($sformatf("random packet %0d", n), b, sgn, low);
      end
    end
    $display("checks done, %0d errors", error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    error_count++;
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("checks done, %0d errors", error_count);
    $display("tests failed");
    $finish;
  end

endmodule

/* src/mouse_led_top.sv */
// ps2 mouse led and cursor top
module mouse_led_top import mouse_pkg::*; #(
  parameter int FILTER_LEN     = 8,
  parameter int INHIBIT_CYCLES = 10000
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    ps2c_in,
  input  logic    ps2d_in,
  output logic    ps2c_drive_low,
  output logic    ps2d_drive_low,
  output led_t    led,
  output cursor_t cursor
);

  logic           ps2c_fall;
  logic           ps2d_bit;
  logic           tx_idle;
  logic           tx_start;
  logic           tx_done_tick;
  ps2_byte_t      tx_byte;
  ps2_byte_t      rx_byte;
  logic           rx_done_tick;
  mouse_move_t    x_move;
  mouse_buttons_t buttons;
  logic           report_tick;

  // line conditioning
  ps2_line_sync #(.FILTER_LEN(FILTER_LEN)) i_ps2_line_sync (
    .clk, .reset, .ps2c_in, .ps2d_in, .ps2c_fall, .ps2d_bit
  );

  ps2_rx i_ps2_rx (
    .clk, .reset, .ps2c_fall, .ps2d_bit, .tx_idle, .rx_byte, .rx_done_tick
  );

  ps2_tx #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) i_ps2_tx (
    .clk, .reset, .ps2c_fall, .ps2d_bit, .tx_start, .tx_byte,
    .ps2c_drive_low, .ps2d_drive_low, .tx_idle, .tx_done_tick
  );

  // init sequence and packet framing
  mouse_packet i_mouse_packet (
    .clk, .reset, .rx_byte, .rx_done_tick, .tx_done_tick,
    .tx_start, .tx_byte, .x_move, .buttons, .report_tick
  );

  // both consumers take every report
  cursor_counter i_cursor_counter (
    .clk, .reset, .report_tick, .x_move, .buttons, .cursor
  );

  led_pattern i_led_pattern (
    .clk, .reset, .report_tick, .x_move, .buttons, .led
  );

endmodule

/* src/led_pattern.sv */
// led rotation pattern
module led_pattern import mouse_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           report_tick,
  input  mouse_move_t    x_move,
  input  mouse_buttons_t buttons,
  output led_t           led
);

  led_t       led_q;
  logic [7:0] x_low;
  led_t       rot_left;
  led_t       rot_right;

  assign x_low     = x_move[7:0];
  // msb wraps to bit 0
  assign rot_left  = {led_q[6:0], led_q[7]};
  // bit 0 wraps to msb
  assign rot_right = {led_q[0], led_q[7:1]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      led_q <= LED_RESET;
    end else if (report_tick) begin
      if (x_low != '0) begin
        // movement takes priority over buttons
        if (x_move[8] && x_low > MOVE_THRESHOLD) begin
          led_q <= rot_right;
        end else if (x_low < MOVE_THRESHOLD) begin
          led_q <= rot_left;
        end
        // low byte equal to threshold holds
      end else if (buttons != '0) begin
        if (buttons[2]) begin
          led_q <= rot_left;
        end else begin
          // left/right pattern in the top three leds
          led_q <= {buttons, 5'd0};
        end
      end
    end
  end

  assign led = led_q;

endmodule

/* src/cursor_counter.sv */
// cursor position counter
module cursor_counter import mouse_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           report_tick,
  input  mouse_move_t    x_move,
  input  mouse_buttons_t buttons,
  output cursor_t        cursor
);

  cursor_t cursor_q;
  cursor_t x_ext;

  // sign extend 9 to 10 bits
  assign x_ext = {x_move[8], x_move};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cursor_q <= CURSOR_RESET;
    end else if (report_tick) begin
      if (buttons[0]) begin
        // left wins over right
        cursor_q <= '0;
      end else if (buttons[1]) begin
        cursor_q <= '1;
      end else begin
        // wraps mod 1024
        cursor_q <= cursor_q + x_ext;
      end
    end
  end

  assign cursor = cursor_q;

endmodule

/* src/mouse_packet.sv */
// mouse init and packet assembly
module mouse_packet import mouse_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  ps2_byte_t      rx_byte,
  input  logic           rx_done_tick,
  input  logic           tx_done_tick,
  output logic           tx_start,
  output ps2_byte_t      tx_byte,
  output mouse_move_t    x_move,
  output mouse_buttons_t buttons,
  output logic           report_tick
);

  typedef enum logic [2:0] {
    SEND_CMD,
    WAIT_TX,
    WAIT_ACK,
    BYTE1,
    BYTE2,
    BYTE3
  } pkt_state_t;

  pkt_state_t     state_q;
  logic           start_q;
  logic           report_q;
  logic           sign_q;
  logic [7:0]     x_low_q;
  mouse_buttons_t btn_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q  <= SEND_CMD;
      start_q  <= 1'b0;
      report_q <= 1'b0;
    end else begin
      start_q  <= 1'b0;
      report_q <= 1'b0;
      case (state_q)
        // single request, no retry
        SEND_CMD: begin
          start_q <= 1'b1;
          state_q <= WAIT_TX;
        end
        WAIT_TX:  if (tx_done_tick) state_q <= WAIT_ACK;
        WAIT_ACK: if (rx_done_tick && rx_byte == RESP_ACK) state_q <= BYTE1;
        BYTE1:    if (rx_done_tick) state_q <= BYTE2;
        BYTE2:    if (rx_done_tick) state_q <= BYTE3;
        BYTE3: begin
          // y byte closes the packet
          if (rx_done_tick) begin
            report_q <= 1'b1;
            state_q  <= BYTE1;
          end
        end
        default: state_q <= SEND_CMD;
      endcase
    end
  end

  // packet fields
  always_ff @(posedge clk) begin
    if (rx_done_tick && state_q == BYTE1) begin
      btn_q  <= rx_byte[2:0];
      sign_q <= rx_byte[4];
    end
    if (rx_done_tick && state_q == BYTE2) begin
      x_low_q <= rx_byte;
    end
  end

  assign tx_start    = start_q;
  assign tx_byte     = CMD_STREAM_ENABLE;
  assign x_move      = {sign_q, x_low_q};
  assign buttons     = btn_q;
  assign report_tick = report_q;

  // the one command finishes only while it is awaited
  a_tx_done_while_waiting: assert property (@(posedge clk) disable iff (reset)
    tx_done_tick |-> (state_q == WAIT_TX));

endmodule

/* src/ps2_tx.sv */
// ps2 host to device byte transmitter
module ps2_tx import mouse_pkg::*; #(
  parameter int INHIBIT_CYCLES = 10000
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      ps2c_fall,
  input  logic      ps2d_bit,
  input  logic      tx_start,
  input  ps2_byte_t tx_byte,
  output logic      ps2c_drive_low,
  output logic      ps2d_drive_low,
  output logic      tx_idle,
  output logic      tx_done_tick
);

  localparam int INH_W = $clog2(INHIBIT_CYCLES + 1);

  typedef enum logic [2:0] {
    IDLE,
    INHIBIT,
    REQUEST,
    SHIFT,
    WAIT_ACK,
    DONE
  } tx_state_t;

  tx_state_t        state_q;
  logic [INH_W-1:0] inh_cnt_q;
  logic [8:0]       shift_q;
  logic [3:0]       bit_cnt_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q   <= IDLE;
      inh_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (tx_start) begin
            inh_cnt_q <= INH_W'(INHIBIT_CYCLES - 1);
            state_q   <= INHIBIT;
          end
        end
        INHIBIT: begin
          // clock held low, device must abort anything in flight
          if (inh_cnt_q == '0) begin
            state_q <= REQUEST;
          end else begin
            inh_cnt_q <= inh_cnt_q - 1'b1;
          end
        end
        REQUEST: begin
          // start bit on the wire, wait for device to clock
          if (ps2c_fall) begin
            bit_cnt_q <= '0;
            state_q   <= SHIFT;
          end
        end
        SHIFT: begin
          if (ps2c_fall) begin
            // 8 data + parity, then release for stop
            if (bit_cnt_q == 4'd8) begin
              state_q <= WAIT_ACK;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        WAIT_ACK: begin
          // device pulls data low on its last clock
          if (ps2c_fall && !ps2d_bit) begin
            state_q <= DONE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // byte plus odd parity, shifted lsb first
  always_ff @(posedge clk) begin
    if (state_q == IDLE && tx_start) begin
      shift_q <= {~^tx_byte, tx_byte};
    end else if (state_q == SHIFT && ps2c_fall) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign ps2c_drive_low = (state_q == INHIBIT);
  // data goes low on the last inhibit cycle, before clock release
  assign ps2d_drive_low = (state_q == INHIBIT && inh_cnt_q == '0) ||
                          (state_q == REQUEST) ||
                          (state_q == SHIFT && !shift_q[0]);
  assign tx_idle      = (state_q == IDLE);
  assign tx_done_tick = (state_q == DONE);

  a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> tx_idle);

  // request to send, data already low when the clock is let go
  a_data_low_at_release: assert property (@(posedge clk) disable iff (reset)
    $fell(ps2c_drive_low) |-> $past(ps2d_drive_low));

endmodule

/* src/ps2_rx.sv */
// ps2 device to host frame receiver
module ps2_rx import mouse_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      ps2c_fall,
  input  logic      ps2d_bit,
  input  logic      tx_idle,
  output ps2_byte_t rx_byte,
  output logic      rx_done_tick
);

  typedef enum logic {
    IDLE,
    SHIFT
  } rx_state_t;

  rx_state_t   state_q;
  logic [3:0]  bits_left_q;
  logic [10:0] frame_q;
  logic [10:0] frame_shift;
  logic        frame_ok;
  logic        done_q;

  // lsb first, new bit enters at the top
  assign frame_shift = {ps2d_bit, frame_q[10:1]};

  // start low, odd parity over data and parity, stop high
  assign frame_ok = !frame_shift[0] && (^frame_shift[9:1]) && frame_shift[10];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q     <= IDLE;
      bits_left_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          // host owns the bus while sending
          if (ps2c_fall && tx_idle) begin
            bits_left_q <= 4'd10;
            state_q     <= SHIFT;
          end
        end
        SHIFT: begin
          if (ps2c_fall) begin
            bits_left_q <= bits_left_q - 1'b1;
            if (bits_left_q == 4'd1) begin
              // stop bit just taken
              done_q  <= frame_ok;
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // frame shifter, no reset needed on payload
  always_ff @(posedge clk) begin
    if (ps2c_fall && (state_q == SHIFT || tx_idle)) begin
      frame_q <= frame_shift;
    end
  end

  assign rx_byte      = frame_q[8:1];
  assign rx_done_tick = done_q;

  // receiver stays quiet for the whole host transmission
  a_no_rx_during_tx: assert property (@(posedge clk) disable iff (reset)
    rx_done_tick |-> tx_idle);

endmodule

/* src/ps2_line_sync.sv */
// ps2 line synchronizer and clock filter
module ps2_line_sync #(
  parameter int FILTER_LEN = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic ps2c_in,
  input  logic ps2d_in,
  output logic ps2c_fall,
  output logic ps2d_bit
);

  localparam int CNT_W = $clog2(FILTER_LEN + 1);

  logic [1:0]       c_sync_q;
  logic [1:0]       d_sync_q;
  logic             c_filt_q;
  logic [CNT_W-1:0] cnt_q;
  logic             fall_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // idle bus is high on both lines
      c_sync_q <= 2'b11;
      d_sync_q <= 2'b11;
      c_filt_q <= 1'b1;
      cnt_q    <= '0;
      fall_q   <= 1'b0;
    end else begin
      c_sync_q <= {c_sync_q[0], ps2c_in};
      d_sync_q <= {d_sync_q[0], ps2d_in};
      fall_q   <= 1'b0;
      if (c_sync_q[1] == c_filt_q) begin
        // agreement, restart the run
        cnt_q <= '0;
      end else if (cnt_q == CNT_W'(FILTER_LEN - 1)) begin
        c_filt_q <= c_sync_q[1];
        cnt_q    <= '0;
        // old level high means this is a falling edge
        fall_q   <= c_filt_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign ps2c_fall = fall_q;
  // data is stable while clock is low, no filter needed
  assign ps2d_bit  = d_sync_q[1];

endmodule

/* src/mouse_pkg.sv */
// mouse front end shared definitions
package mouse_pkg;

  // one byte on the ps2 wire
  typedef logic [7:0] ps2_byte_t;
  // bit 8 is the sign from packet byte 1, bits 7..0 from byte 2
  typedef logic signed [8:0] mouse_move_t;
  // bit 0 left, bit 1 right, bit 2 middle
  typedef logic [2:0] mouse_buttons_t;
  typedef logic [9:0] cursor_t;
  typedef logic [7:0] led_t;

  // host to mouse, enable data reporting
  localparam ps2_byte_t CMD_STREAM_ENABLE = 8'hF4;
  // mouse answer to any accepted command
  localparam ps2_byte_t RESP_ACK = 8'hFA;

  localparam cursor_t CURSOR_RESET = 10'd3;
  localparam led_t    LED_RESET    = 8'h01;
  // x magnitude that splits left and right rotation
  localparam logic [7:0] MOVE_THRESHOLD = 8'd100;

endpackage
